// ==== cw_reg.f ====
hdl/cw_regmap_pkg.sv
hdl/cw_route_pkg.sv
hdl/cw_reg_file.sv
hdl/trigger_router.sv
hdl/target_io_router.sv
hdl/cw_reg_top.sv
tests/cw_reg_top_asserts.sv
tests/tb_cw_reg_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cw_reg_top
RTL_TOP   ?= cw_reg_top
FILELIST  ?= cw_reg.f
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_cw_reg_top.sv ====
`timescale 1ns/1ps

module tb_cw_reg_top;

   typedef enum {OP_WR, OP_RD, OP_TRIG, OP_PADS, OP_IDLE} op_e;

   // everything driven into the DUT apart from the bus
   typedef struct packed {
      logic                   aux;
      logic                   nrst;
      logic [3:0]             io;
      logic [7:0]             userio;
      cw_route_pkg::trig_in_t mt;
      logic                   uart_tx;
      logic [3:0]             pad;
      logic [3:0]             sense;
   } stim_in_t;

   typedef struct {
      op_e                    op;
      logic [7:0]             addr;
      logic [6:0]             bc;
      logic [7:0]             data;         // write data or expected read byte
      stim_in_t               in;
      logic [5:0]             exp_trig;     // ext, capture, glitch, decodeio, sad, edge
      logic [5:0]             trig_mask;    // which trigger bits are checked
      cw_route_pkg::pad_out_t exp_pads;
      logic                   exp_rx;
      logic                   exp_tpo;
      cw_route_pkg::ovr_out_t exp_ovr;      // nRST / PDID / PDIC override outputs
      logic                   exp_avr;
   } row_t;

   logic                                 clk_usb = 1'b0;
   logic                                 reset;
   cw_regmap_pkg::reg_bus_t              bus;
   logic [7:0]                           rdata;
   stim_in_t                             drv;
   logic                                 trigger_ext, trigger_capture, trigger_glitch;
   logic                                 decodeio_active, sad_active, edge_active;
   cw_route_pkg::pad_out_t               pads;
   cw_route_pkg::ovr_out_t               ovr;
   logic                                 uart_rx, targetpower_off, avr_prog;

   row_t       rows[$];
   stim_in_t   cur;                 // inputs copied into every new row
   cw_route_pkg::ovr_out_t ovr_exp; // override levels expected from here on
   logic       avr_exp;
   logic [31:0] lfsr_q = 32'd68983;
   int         n_rows = 0;

   always #5 clk_usb = ~clk_usb;

   cw_reg_top i_dut (
      .clk_usb (clk_usb), .reset (reset), .bus_i (bus), .rdata_o (rdata),
      .aux_i (drv.aux), .nrst_i (drv.nrst), .io_i (drv.io), .userio_i (drv.userio),
      .mod_trig_i (drv.mt), .trigger_ext_o (trigger_ext), .trigger_capture_o (trigger_capture),
      .trigger_glitch_o (trigger_glitch), .decodeio_active_o (decodeio_active),
      .sad_active_o (sad_active), .edge_active_o (edge_active),
      .uart_tx_i (drv.uart_tx), .pad_i (drv.pad), .sense_i (drv.sense),
      .pad_o (pads), .ovr_o (ovr), .uart_rx_o (uart_rx),
      .targetpower_off_o (targetpower_off), .avr_prog_o (avr_prog)
   );

   // galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);   // one step per bit
         v[i]   = lfsr_q[0];
      end
      return v;
   endfunction

   // enabled sources only; OFF never fires
   function automatic logic ext_model(input logic [1:0] mode, input logic [13:0] src,
                                      input logic [13:0] en);
      logic any_hi;
      logic all_hi;
      any_hi = 1'b0;
      all_hi = 1'b1;
      for (int i = 0; i < 14; i++) begin
         if (en[i]) begin
            any_hi = any_hi | src[i];
            all_hi = all_hi & src[i];
         end
      end
      case (mode)
         2'd0:    return any_hi;
         2'd1:    return all_hi;
         2'd2:    return ~all_hi;
         default: return 1'b0;
      endcase
   endfunction

   function automatic row_t new_row(input op_e op);
      row_t r;
      r           = '{op: op, addr: 8'h00, bc: 7'd0, data: 8'h00, in: cur, exp_trig: 6'd0,
                      trig_mask: 6'd0, exp_pads: '0, exp_rx: 1'b1, exp_tpo: 1'b0,
                      exp_ovr: ovr_exp, exp_avr: avr_exp};
      return r;
   endfunction

   task automatic add_bus(input op_e op, input logic [7:0] a, input int bc, input logic [7:0] d);
      row_t r;
      r      = new_row(op);
      r.addr = a;
      r.bc   = 7'(bc);
      r.data = d;
      rows.push_back(r);
   endtask

   task automatic add_trig(input logic [5:0] exp, input logic [5:0] mask);
      row_t r;
      r           = new_row(OP_TRIG);
      r.exp_trig  = exp;
      r.trig_mask = mask;
      rows.push_back(r);
   endtask

   task automatic add_pads(input logic [3:0] en, input logic [3:0] val, input logic rx,
                           input logic tpo);
      row_t r;
      r          = new_row(OP_PADS);
      r.exp_pads = '{en: en, val: val};
      r.exp_rx   = rx;
      r.exp_tpo  = tpo;
      rows.push_back(r);
   endtask

   task automatic fail_mismatch(input string msg);
      $display("Mismatch at %0t ns: %s", $time, msg);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
   endtask

   task automatic check_rdata(input logic [7:0] got, input logic [7:0] exp, input int k);
      if (got !== exp) fail_mismatch($sformatf("row %0d rdata 0x%02h, expected 0x%02h",
                                               k, got, exp));
   endtask

   task automatic check_trig(input logic [5:0] got, input logic [5:0] exp,
                             input logic [5:0] mask, input int k);
      if (((got ^ exp) & mask) != 6'd0 || $isunknown(got & mask))
         fail_mismatch($sformatf("row %0d triggers %b, expected %b (mask %b)",
                                 k, got, exp, mask));
   endtask

   task automatic check_pads(input cw_route_pkg::pad_out_t got,
                             input cw_route_pkg::pad_out_t exp, input int k);
      // value only matters on enabled pins
      if (got.en !== exp.en || (got.val & exp.en) !== (exp.val & exp.en))
         fail_mismatch($sformatf("row %0d pads en %b val %b, expected en %b val %b",
                                 k, got.en, got.val, exp.en, exp.val));
   endtask

   task automatic check_ovr(input cw_route_pkg::ovr_out_t got,
                            input cw_route_pkg::ovr_out_t exp, input int k);
      if (got !== exp) fail_mismatch($sformatf("row %0d overrides %b, expected %b",
                                               k, got, exp));
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what, input int k);
      if (got !== exp) fail_mismatch($sformatf("row %0d %s %b, expected %b", k, what, got, exp));
   endtask

   task automatic build_table();
      logic [5:0]  pmask;
      logic [7:0]  umask;
      logic        ext;
      logic        cap;
      cur     = '0;
      ovr_exp = '0;
      avr_exp = 1'b0;
      // reset values and an unknown address
      add_bus(OP_RD, cw_regmap_pkg::CW_TRIGSRC_ADDR, 0, 8'h20);
      add_bus(OP_RD, cw_regmap_pkg::CW_TRIGSRC_ADDR, 1, 8'h00);
      add_bus(OP_RD, cw_regmap_pkg::CW_TRIGMOD_ADDR, 0, 8'h00);
      for (int l = 0; l < 8; l++)
         add_bus(OP_RD, cw_regmap_pkg::CW_IOROUTE_ADDR, l,
                 (l == 0) ? 8'h01 : (l == 1) ? 8'h02 : 8'h00);
      add_bus(OP_RD, 8'h50, 0, 8'h00);
      // lane writes
      add_bus(OP_WR, cw_regmap_pkg::CW_TRIGSRC_ADDR, 1, 8'hA5);
      add_bus(OP_RD, cw_regmap_pkg::CW_TRIGSRC_ADDR, 0, 8'h20);   // lane 0 untouched
      add_bus(OP_RD, cw_regmap_pkg::CW_TRIGSRC_ADDR, 1, 8'hA5);
      add_bus(OP_WR, cw_regmap_pkg::CW_IOROUTE_ADDR, 4, 8'h3C);
      add_bus(OP_RD, cw_regmap_pkg::CW_IOROUTE_ADDR, 4, 8'h3C);
      add_bus(OP_RD, cw_regmap_pkg::CW_IOROUTE_ADDR, 3, 8'h00);
      // random masks and sources in each combine mode with module EXT
      for (int m = 0; m < 4; m++) begin
         pmask = rand_bits(6);
         umask = rand_bits(8);
         add_bus(OP_WR, cw_regmap_pkg::CW_TRIGSRC_ADDR, 0, {2'(m), pmask});
         add_bus(OP_WR, cw_regmap_pkg::CW_TRIGSRC_ADDR, 1, umask);
         for (int n = 0; n < 4; n++) begin
            cur.aux    = rand_bits(1) != 8'd0;
            cur.nrst   = rand_bits(1) != 8'd0;
            cur.io     = 4'(rand_bits(4));
            cur.userio = rand_bits(8);
            ext = ext_model(2'(m), {cur.userio, cur.io, cur.nrst, cur.aux}, {umask, pmask});
            add_trig({ext, ext, 4'b0000}, 6'b110111);
         end
      end
      // module select with aux alone through OR
      add_bus(OP_WR, cw_regmap_pkg::CW_TRIGSRC_ADDR, 0, 8'h01);
      add_bus(OP_WR, cw_regmap_pkg::CW_TRIGSRC_ADDR, 1, 8'h00);
      for (int m = 0; m < 8; m++) begin
         add_bus(OP_WR, cw_regmap_pkg::CW_TRIGMOD_ADDR, 0, 8'(m));
         cur.aux = rand_bits(1) != 8'd0;
         cur.mt  = 6'(rand_bits(6));
         case (m)
            0:       cap = cur.aux;
            1:       cap = cur.mt.advio;
            2:       cap = cur.mt.sad;
            3:       cap = cur.mt.decodedio;
            4:       cap = cur.mt.trace;
            5:       cap = cur.mt.adc;
            6:       cap = cur.mt.edge_trig;
            default: cap = 1'b0;
         endcase
         add_trig({cur.aux, cap, 1'b0, m == 3, m == 2, m == 6}, 6'b110111);
      end
      // glitch pulse from aux low for two cycles then held high
      add_bus(OP_WR, cw_regmap_pkg::CW_TRIGMOD_ADDR, 0, 8'h00);
      cur.aux = 1'b0;
      add_trig(6'b000000, 6'b111111);
      add_trig(6'b000000, 6'b111111);
      cur.aux = 1'b1;
      add_trig(6'b111000, 6'b111111);
      add_trig(6'b111000, 6'b111111);
      add_trig(6'b110000, 6'b111111);   // pulse over once high for two cycles
      // a fresh ext edge under SAD stays off the glitch output
      cur.aux = 1'b0;
      cur.mt  = '0;
      add_bus(OP_WR, cw_regmap_pkg::CW_TRIGMOD_ADDR, 0, 8'h02);
      add_trig(6'b000010, 6'b111111);
      cur.aux = 1'b1;
      add_trig(6'b100010, 6'b111111);
      cur = '0;
      // pin priority with pins 4..1 in bits 3..0
      add_bus(OP_WR, cw_regmap_pkg::CW_IOROUTE_ADDR, 0, 8'h81);   // tx over gpio
      add_bus(OP_WR, cw_regmap_pkg::CW_IOROUTE_ADDR, 1, 8'h12);   // rx and an ignored force-low
      add_bus(OP_WR, cw_regmap_pkg::CW_IOROUTE_ADDR, 2, 8'h30);   // force-low over oc
      add_bus(OP_WR, cw_regmap_pkg::CW_IOROUTE_ADDR, 3, 8'hC2);   // gpio high with rx
      cur.uart_tx = 1'b1;
      cur.pad     = 4'b1010;
      add_pads(4'b1101, 4'b1001, 1'b1, 1'b0);
      cur.uart_tx = 1'b0;
      cur.pad     = 4'b1000;
      add_pads(4'b1101, 4'b1000, 1'b0, 1'b0);
      add_bus(OP_WR, cw_regmap_pkg::CW_IOROUTE_ADDR, 2, 8'h20);   // pin 3 open collector
      cur.uart_tx = 1'b1;
      cur.pad     = 4'b1010;
      add_pads(4'b1001, 4'b1001, 1'b1, 1'b0);
      cur.uart_tx = 1'b0;
      cur.pad     = 4'b0101;
      add_pads(4'b1101, 4'b1000, 1'b0, 1'b0);
      add_bus(OP_WR, cw_regmap_pkg::CW_IOROUTE_ADDR, 1, 8'h00);   // rx moves to pin 4
      cur.pad = 4'b0111;
      add_pads(4'b1101, 4'b1000, 1'b0, 1'b0);
      cur.pad = 4'b1000;
      add_pads(4'b1101, 4'b1000, 1'b1, 1'b0);
      add_bus(OP_WR, cw_regmap_pkg::CW_IOROUTE_ADDR, 3, 8'h80);   // no rx left and gpio low
      cur.uart_tx = 1'b1;
      cur.pad     = 4'b0000;
      add_pads(4'b1001, 4'b0001, 1'b1, 1'b0);
      // nrst_en, pdid_en and the pdic level
      add_bus(OP_WR, cw_regmap_pkg::CW_IOROUTE_ADDR, 6, 8'h25);
      ovr_exp = '{pdic: 1'b1, pdic_en: 1'b0, pdid: 1'b0, pdid_en: 1'b1,
                  nrst: 1'b0, nrst_en: 1'b1};
      // power off with avr programming, switch one cycle later and pins one more
      add_bus(OP_WR, cw_regmap_pkg::CW_IOROUTE_ADDR, 5, 8'h03);
      avr_exp = 1'b1;
      add_pads(4'b1001, 4'b0001, 1'b1, 1'b0);
      add_pads(4'b1001, 4'b0001, 1'b1, 1'b1);
      add_pads(4'b0000, 4'b0001, 1'b1, 1'b1);
      add_bus(OP_RD, cw_regmap_pkg::CW_IOROUTE_ADDR, 5, 8'h03);
      // sampled pins held two cycles before the read
      cur.pad   = 4'hA;
      cur.sense = 4'h5;
      rows.push_back(new_row(OP_IDLE));
      rows.push_back(new_row(OP_IDLE));
      add_bus(OP_RD, cw_regmap_pkg::CW_IOREAD_ADDR, 0, 8'h5A);
   endtask

   initial begin
      wait (n_rows > 0);
      repeat (n_rows * 20 + 10) @(posedge clk_usb);
      $display("Timeout: table not finished after %0d cycles", n_rows * 20 + 10);
      $display("RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

   initial begin
      row_t r;
      reset = 1'b1;
      bus   = '0;
      drv   = '0;
      build_table();
      n_rows = rows.size();
      repeat (4) @(posedge clk_usb);
      @(negedge clk_usb);
      reset = 1'b0;
      repeat (2) @(negedge clk_usb);   // power confirmed on before the first row
      for (int k = 0; k < rows.size(); k++) begin
         @(negedge clk_usb);
         r           = rows[k];
         bus.addr    = r.addr;
         bus.bytecnt = r.bc;
         bus.wdata   = r.data;
         bus.rd      = (r.op == OP_RD);
         bus.wr      = (r.op == OP_WR);
         drv         = r.in;
         #1;
         case (r.op)
            OP_RD:   check_rdata(rdata, r.data, k);
            OP_TRIG: check_trig({trigger_ext, trigger_capture, trigger_glitch,
                                 decodeio_active, sad_active, edge_active},
                                r.exp_trig, r.trig_mask, k);
            OP_PADS: begin
               check_pads(pads, r.exp_pads, k);
               check_bit(uart_rx, r.exp_rx, "uart_rx", k);
               check_bit(targetpower_off, r.exp_tpo, "targetpower_off", k);
               check_ovr(ovr, r.exp_ovr, k);
               check_bit(avr_prog, r.exp_avr, "avr_prog", k);
            end
            default: begin
            end
         endcase
      end
      @(negedge clk_usb);
      bus = '0;
      @(negedge clk_usb);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== tests/cw_reg_top_asserts.sv ====
`timescale 1ns/1ps

// protocol and routing properties of the config block top level
module cw_reg_top_asserts (
   input logic                                clk_usb,
   input logic                                reset,
   input logic                                rd_i,        // bus read strobe
   input logic [cw_regmap_pkg::DATA_W-1:0]    rdata_i,
   input logic                                tpo_i,       // target power off
   input logic [cw_route_pkg::NUM_PINS-1:0]   pad_en_i,
   input logic                                ext_i,
   input logic                                glitch_i
);

   // read data idles at zero between reads
   rdata_idle_zero: assert property (@(posedge clk_usb) disable iff (reset)
      !rd_i |-> (rdata_i == '0))
      else $error("read data nonzero without a read strobe");

   // pins released one edge after the power switch opens
   pins_off_after_power: assert property (@(posedge clk_usb) disable iff (reset)
      tpo_i |=> (pad_en_i == '0))
      else $error("pin enabled while target power is off");

   glitch_needs_ext: assert property (@(posedge clk_usb) disable iff (reset)
      glitch_i |-> ext_i)
      else $error("glitch trigger without external trigger");

endmodule

bind cw_reg_top cw_reg_top_asserts i_asserts (
   .clk_usb  (clk_usb),
   .reset    (reset),
   .rd_i     (bus_i.rd),
   .rdata_i  (rdata_o),
   .tpo_i    (targetpower_off_o),
   .pad_en_i (pad_o.en),
   .ext_i    (trigger_ext_o),
   .glitch_i (trigger_glitch_o)
);

// ==== hdl/cw_reg_top.sv ====
`timescale 1ns/1ps

// config register block, register file feeding the trigger and io routers
module cw_reg_top (
   input  logic                                  clk_usb,
   input  logic                                  reset,
   // register bus
   input  cw_regmap_pkg::reg_bus_t               bus_i,
   output logic [cw_regmap_pkg::DATA_W-1:0]      rdata_o,
   // trigger side
   input  logic                                  aux_i,
   input  logic                                  nrst_i,
   input  logic [cw_route_pkg::NUM_PINS-1:0]     io_i,
   input  logic [cw_route_pkg::NUM_USERIO-1:0]   userio_i,
   input  cw_route_pkg::trig_in_t                mod_trig_i,
   output logic                                  trigger_ext_o,
   output logic                                  trigger_capture_o,
   output logic                                  trigger_glitch_o,
   output logic                                  decodeio_active_o,
   output logic                                  sad_active_o,
   output logic                                  edge_active_o,
   // target side
   input  logic                                  uart_tx_i,
   input  logic [cw_route_pkg::NUM_PINS-1:0]     pad_i,
   input  logic [3:0]                            sense_i,
   output cw_route_pkg::pad_out_t                pad_o,
   output cw_route_pkg::ovr_out_t                ovr_o,
   output logic                                  uart_rx_o,
   output logic                                  targetpower_off_o,
   output logic                                  avr_prog_o
);

   cw_route_pkg::trigsrc_u      trigsrc;     // source mask and combine mode
   cw_route_pkg::trig_module_e  trigmod;
   cw_route_pkg::iorouting_u    iorouting;
   cw_regmap_pkg::ioread_t      ioread;      // back to the register file

   cw_reg_file i_reg_file (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .bus_i       (bus_i),
      .rdata_o     (rdata_o),
      .ioread_i    (ioread),
      .trigsrc_o   (trigsrc),
      .trigmod_o   (trigmod),
      .iorouting_o (iorouting)
   );

   trigger_router i_trigger_router (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .trigsrc_i         (trigsrc),
      .trigmod_i         (trigmod),
      .aux_i             (aux_i),
      .nrst_i            (nrst_i),
      .io_i              (io_i),
      .userio_i          (userio_i),
      .mod_trig_i        (mod_trig_i),
      .trigger_ext_o     (trigger_ext_o),
      .trigger_capture_o (trigger_capture_o),
      .trigger_glitch_o  (trigger_glitch_o),
      .decodeio_active_o (decodeio_active_o),
      .sad_active_o      (sad_active_o),
      .edge_active_o     (edge_active_o)
   );

   target_io_router i_target_io_router (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .iorouting_i       (iorouting),
      .uart_tx_i         (uart_tx_i),
      .pad_i             (pad_i),
      .sense_i           (sense_i),
      .pad_o             (pad_o),
      .ovr_o             (ovr_o),
      .uart_rx_o         (uart_rx_o),
      .targetpower_off_o (targetpower_off_o),
      .avr_prog_o        (avr_prog_o),
      .ioread_o          (ioread)
   );

endmodule

// ==== hdl/target_io_router.sv ====
`timescale 1ns/1ps

// target power, pin drive, uart rx select and pin sampling
module target_io_router (
   input  logic                               clk_usb,
   input  logic                               reset,
   input  cw_route_pkg::iorouting_u           iorouting_i,
   input  logic                               uart_tx_i,
   input  logic [cw_route_pkg::NUM_PINS-1:0]  pad_i,        // target io 4..1
   input  logic [3:0]                         sense_i,      // pdid, pdic, miso, mosi
   output cw_route_pkg::pad_out_t             pad_o,
   output cw_route_pkg::ovr_out_t             ovr_o,
   output logic                               uart_rx_o,
   output logic                               targetpower_off_o,
   output logic                               avr_prog_o,
   output cw_regmap_pkg::ioread_t             ioread_o
);

   logic                              pwr_off_q;    // drives the power switch
   logic                              pins_off_q;   // pins wait one more edge after the switch
   logic [cw_route_pkg::NUM_PINS-1:0] pin_val;
   logic [cw_route_pkg::NUM_PINS-1:0] pin_en;

   // power comes up off, pins stay quiet until it is confirmed on
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pwr_off_q  <= 1'b1;
         pins_off_q <= 1'b1;
      end else begin
         pwr_off_q  <= iorouting_i.fld.extra.power_off;
         pins_off_q <= pwr_off_q;
      end
   end

   assign targetpower_off_o = pwr_off_q;
   assign avr_prog_o        = iorouting_i.fld.extra.avr_prog;
   assign ovr_o             = iorouting_i.fld.xgpio.ovr;

   // per pin drive, lowest route bit wins
   always_comb begin
      cw_route_pkg::gpio_route_t r;
      for (int i = 0; i < cw_route_pkg::NUM_PINS; i++) begin
         r          = iorouting_i.fld.gpio[i];
         pin_val[i] = 1'b0;
         pin_en[i]  = 1'b0;
         if (r.tx) begin
            pin_val[i] = uart_tx_i;
            pin_en[i]  = 1'b1;
         end else if ((i == cw_route_pkg::OC_PIN) && r.force_low) begin
            pin_en[i]  = 1'b1;                 // hold target line low
         end else if ((i == cw_route_pkg::OC_PIN) && r.oc_tx) begin
            pin_en[i]  = ~uart_tx_i;           // pull low only, release for a 1
         end else if (r.gpio_en) begin
            pin_val[i] = r.gpio_level;
            pin_en[i]  = 1'b1;
         end
      end
   end

   assign pad_o = '{en: pin_en & {cw_route_pkg::NUM_PINS{~pins_off_q}}, val: pin_val};

   // uart rx from the lowest pin flagged rx, idle high otherwise
   always_comb begin
      uart_rx_o = 1'b1;
      for (int i = cw_route_pkg::NUM_PINS - 1; i >= 0; i--) begin
         if (iorouting_i.fld.gpio[i].rx) begin
            uart_rx_o = pad_i[i];
         end
      end
   end

   // IOREAD snapshot, taken every edge
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ioread_o <= '0;
      end else begin
         ioread_o <= {sense_i, pad_i};
      end
   end

endmodule

// ==== hdl/trigger_router.sv ====
`timescale 1ns/1ps

// combines the external trigger sources and picks the capture trigger
module trigger_router (
   input  logic                                  clk_usb,
   input  logic                                  reset,
   input  cw_route_pkg::trigsrc_u                trigsrc_i,
   input  cw_route_pkg::trig_module_e            trigmod_i,
   input  logic                                  aux_i,        // front panel aux
   input  logic                                  nrst_i,
   input  logic [cw_route_pkg::NUM_PINS-1:0]     io_i,         // target io 4..1
   input  logic [cw_route_pkg::NUM_USERIO-1:0]   userio_i,
   input  cw_route_pkg::trig_in_t                mod_trig_i,   // other trigger modules
   output logic                                  trigger_ext_o,
   output logic                                  trigger_capture_o,
   output logic                                  trigger_glitch_o,
   output logic                                  decodeio_active_o,
   output logic                                  sad_active_o,
   output logic                                  edge_active_o
);

   logic [cw_route_pkg::NUM_TRIG_SRC-1:0] src;       // raw sources, aux in bit 0
   logic [cw_route_pkg::NUM_TRIG_SRC-1:0] src_en;    // enable mask from TRIGSRC
   logic                                  trig_or;
   logic                                  trig_and;
   logic [1:0]                            ext_hist;  // trigger_ext one and two edges back
   logic                                  ext_pulse;

   assign src    = {userio_i, io_i, nrst_i, aux_i};
   assign src_en = {trigsrc_i.fld.userio_en,
                    trigsrc_i.fld.io4, trigsrc_i.fld.io3, trigsrc_i.fld.io2, trigsrc_i.fld.io1,
                    trigsrc_i.fld.nrst, trigsrc_i.fld.aux};

   assign trig_or  = |(src & src_en);    // disabled lines count as 0
   assign trig_and = &(src | ~src_en);   // disabled lines count as 1

   always_comb begin
      case (trigsrc_i.fld.combine)
         cw_route_pkg::OR:   trigger_ext_o = trig_or;
         cw_route_pkg::AND:  trigger_ext_o = trig_and;
         cw_route_pkg::NAND: trigger_ext_o = ~trig_and;
         default:            trigger_ext_o = 1'b0;      // OFF
      endcase
   end

   // capture trigger by module
   always_comb begin
      case (trigmod_i)
         cw_route_pkg::EXT:       trigger_capture_o = trigger_ext_o;
         cw_route_pkg::ADVIO:     trigger_capture_o = mod_trig_i.advio;
         cw_route_pkg::SAD:       trigger_capture_o = mod_trig_i.sad;
         cw_route_pkg::DECODEDIO: trigger_capture_o = mod_trig_i.decodedio;
         cw_route_pkg::TRACE:     trigger_capture_o = mod_trig_i.trace;
         cw_route_pkg::ADC:       trigger_capture_o = mod_trig_i.adc;
         cw_route_pkg::EDGE:      trigger_capture_o = mod_trig_i.edge_trig;
         default:                 trigger_capture_o = 1'b0;   // NONE
      endcase
   end

   // glitch side sees trigger_ext through two flops
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ext_hist <= 2'b00;
      end else begin
         ext_hist <= {ext_hist[0], trigger_ext_o};
      end
   end

   // live level against the older sample keeps the pulse free of extra latency
   assign ext_pulse        = trigger_ext_o & ~ext_hist[1];
   assign trigger_glitch_o = (trigmod_i == cw_route_pkg::EXT) ? ext_pulse : 1'b0;

   assign decodeio_active_o = (trigmod_i == cw_route_pkg::DECODEDIO);
   assign sad_active_o      = (trigmod_i == cw_route_pkg::SAD);
   assign edge_active_o     = (trigmod_i == cw_route_pkg::EDGE);

endmodule

// ==== hdl/cw_reg_file.sv ====
`timescale 1ns/1ps

// config registers of the trigger / io block
// byte wide writes by lane, combinational read-back
module cw_reg_file (
   input  logic                                   clk_usb,
   input  logic                                   reset,
   input  cw_regmap_pkg::reg_bus_t                bus_i,
   output logic [cw_regmap_pkg::DATA_W-1:0]       rdata_o,
   input  cw_regmap_pkg::ioread_t                 ioread_i,     // sampled pins, read only
   output cw_route_pkg::trigsrc_u                 trigsrc_o,
   output cw_route_pkg::trig_module_e             trigmod_o,
   output cw_route_pkg::iorouting_u               iorouting_o
);

   logic trigsrc_lane_ok;   // byte count inside TRIGSRC
   logic ioroute_lane_ok;   // byte count inside IOROUTE
   logic ioread_lane_ok;

   assign trigsrc_lane_ok = (bus_i.bytecnt < cw_regmap_pkg::TRIGSRC_BYTES);
   assign ioroute_lane_ok = (bus_i.bytecnt < cw_regmap_pkg::IOROUTE_BYTES);
   assign ioread_lane_ok  = (bus_i.bytecnt < cw_regmap_pkg::IOREAD_BYTES);

   // write side
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         trigsrc_o   <= cw_regmap_pkg::TRIGSRC_RESET;
         trigmod_o   <= cw_route_pkg::EXT;                  // plain edge trigger
         iorouting_o <= cw_regmap_pkg::IOROUTE_RESET;       // pin 1 tx, pin 2 rx
      end else if (bus_i.wr) begin
         case (bus_i.addr)
            cw_regmap_pkg::CW_TRIGSRC_ADDR: begin
               if (trigsrc_lane_ok) begin
                  trigsrc_o.lane[bus_i.bytecnt[0]] <= bus_i.wdata;   // one lane per access
               end
            end
            cw_regmap_pkg::CW_TRIGMOD_ADDR: begin
               trigmod_o <= cw_route_pkg::trig_module_e'(bus_i.wdata[2:0]);   // upper bits dropped
            end
            cw_regmap_pkg::CW_IOROUTE_ADDR: begin
               if (ioroute_lane_ok) begin
                  iorouting_o.lane[bus_i.bytecnt[2:0]] <= bus_i.wdata;
               end
            end
            default: begin
               // IOREAD and unknown addresses ignore writes
            end
         endcase
      end
   end

   // read side, zero unless a read is strobed
   always_comb begin
      rdata_o = '0;
      if (bus_i.rd) begin
         case (bus_i.addr)
            cw_regmap_pkg::CW_TRIGSRC_ADDR: begin
               if (trigsrc_lane_ok) begin
                  rdata_o = trigsrc_o.lane[bus_i.bytecnt[0]];
               end
            end
            cw_regmap_pkg::CW_TRIGMOD_ADDR: begin
               rdata_o = {5'b0, trigmod_o};
            end
            cw_regmap_pkg::CW_IOROUTE_ADDR: begin
               if (ioroute_lane_ok) begin
                  rdata_o = iorouting_o.lane[bus_i.bytecnt[2:0]];   // glitch byte reads back too
               end
            end
            cw_regmap_pkg::CW_IOREAD_ADDR: begin
               if (ioread_lane_ok) begin
                  rdata_o = ioread_i;   // lane 0 only
               end
            end
            default: begin
               rdata_o = '0;            // unmapped
            end
         endcase
      end
   end

endmodule

// ==== hdl/cw_route_pkg.sv ====
// trigger and target io routing layouts
// the unions give the byte view used by the bus and the field view used by the routers
package cw_route_pkg;

   localparam int NUM_PINS     = 4;                          // target io 1..4
   localparam int NUM_USERIO   = 8;                          // user io lines usable as trigger
   localparam int NUM_PIN_SRC  = 6;                          // aux, nrst, io1..io4
   localparam int NUM_TRIG_SRC = NUM_PIN_SRC + NUM_USERIO;   // all combinable sources
   localparam int OC_PIN       = 2;                          // pin 3, only one with force-low / oc tx

   typedef enum logic [1:0] {OR, AND, NAND, OFF} trig_combine_e;

   typedef enum logic [2:0] {
      EXT, ADVIO, SAD, DECODEDIO, TRACE, ADC, EDGE, NONE
   } trig_module_e;

   // TRIGSRC field layout, bit 0 is aux
   typedef struct packed {
      logic [NUM_USERIO-1:0] userio_en;   // bits 15:8
      trig_combine_e         combine;     // bits 7:6
      logic                  io4;
      logic                  io3;
      logic                  io2;
      logic                  io1;
      logic                  nrst;
      logic                  aux;         // bit 0
   } trigsrc_fld_t;

   typedef union packed {
      logic [1:0][7:0] lane;   // bus side
      trigsrc_fld_t    fld;    // trigger router side
   } trigsrc_u;

   // one routing byte per target pin
   typedef struct packed {
      logic gpio_en;      // bit 7, drive gpio_level
      logic gpio_level;
      logic oc_tx;        // open collector tx, pin 3 only
      logic force_low;    // pin 3 only
      logic rsvd3;
      logic rsvd2;
      logic rx;           // pin feeds uart rx
      logic tx;           // bit 0, pin carries uart tx
   } gpio_route_t;

   // nRST / PDID / PDIC overrides, enable below level
   typedef struct packed {
      logic pdic;
      logic pdic_en;
      logic pdid;
      logic pdid_en;
      logic nrst;
      logic nrst_en;
   } ovr_out_t;

   typedef struct packed {
      logic [5:0] rsvd;
      logic       power_off;   // bit 1
      logic       avr_prog;    // bit 0
   } io_extra_t;

   typedef struct packed {
      logic [1:0] rsvd;
      ovr_out_t   ovr;
   } io_xgpio_t;

   typedef struct packed {
      logic [7:0]                 rsvd;     // byte 7
      io_xgpio_t                  xgpio;    // byte 6
      io_extra_t                  extra;    // byte 5
      logic [7:0]                 glitch;   // byte 4, only read back
      gpio_route_t [NUM_PINS-1:0] gpio;     // bytes 3..0, pin 1 in byte 0
   } iorouting_fld_t;

   typedef union packed {
      logic [7:0][7:0] lane;
      iorouting_fld_t  fld;
   } iorouting_u;

   // triggers coming from the other trigger modules
   typedef struct packed {
      logic advio;
      logic sad;
      logic decodedio;
      logic trace;
      logic adc;
      logic edge_trig;
   } trig_in_t;

   typedef struct packed {
      logic [NUM_PINS-1:0] en;    // output enable per pin
      logic [NUM_PINS-1:0] val;   // output value per pin
   } pad_out_t;

endpackage

// ==== hdl/cw_regmap_pkg.sv ====
// register map of the capture board config block
// addresses, bus widths, reset values and the register bus itself
package cw_regmap_pkg;

   // register addresses, one byte each
   localparam logic [7:0] CW_TRIGSRC_ADDR = 8'h27;   // trigger source mask and combine mode
   localparam logic [7:0] CW_TRIGMOD_ADDR = 8'h28;   // trigger module select
   localparam logic [7:0] CW_IOROUTE_ADDR = 8'h37;   // target io routing, 8 bytes
   localparam logic [7:0] CW_IOREAD_ADDR  = 8'h3B;   // sampled target pins

   // bus widths
   localparam int BYTECNT_W = 7;                     // byte count from the host interface
   localparam int DATA_W    = 8;                     // one byte per access

   // number of byte lanes per register
   localparam int TRIGSRC_BYTES = 2;
   localparam int IOROUTE_BYTES = 8;
   localparam int IOREAD_BYTES  = 1;

   // reset values
   localparam logic [15:0] TRIGSRC_RESET = 16'h0020;  // io4 enabled, OR combine
   // byte 0 = pin 1 tx, byte 1 = pin 2 rx, rest cleared
   localparam logic [63:0] IOROUTE_RESET = 64'h0000_0000_0000_0201;

   // register bus request, strobes are single cycle
   typedef struct packed {
      logic [7:0]           addr;      // register address
      logic [BYTECNT_W-1:0] bytecnt;   // byte lane of a multi byte register
      logic [DATA_W-1:0]    wdata;     // write data
      logic                 rd;        // read strobe
      logic                 wr;        // write strobe
   } reg_bus_t;

   // IOREAD byte as seen by the host
   typedef struct packed {
      logic       pdid;    // bit 7
      logic       pdic;
      logic       miso;
      logic       mosi;    // bit 4
      logic [3:0] pins;    // target io 4..1, pin 1 in bit 0
   } ioread_t;

endpackage
